/* source/rvExecPkg.sv */
// Shared widths, encodings and bundles for the RV32I execute core
// Only the integer subset in opcode_e is decoded; LOAD and STORE exist
// here so the decoder can flag them as unsupported
// Funct3 branch codes follow the RISC-V spec

package rvExecPkg;

    //////////////////////////////////////////////////
    // Widths and constants
    //////////////////////////////////////////////////
    localparam int XLEN    = 32;            // Data and address width
    localparam int SHAMT_W = 5;             // Shift amount bits used

    typedef logic [XLEN-1:0] word_t;        // Data or address word
    typedef logic [4:0]      regAddr_t;     // Register index
    typedef logic [2:0]      funct3_t;      // Minor opcode field

    localparam word_t INSN_BYTES = 32'd4;   // Sequential PC step

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP     = 7'b0110011,                // Reg-reg ALU
        OP_IMM = 7'b0010011,                // Reg-imm ALU
        BRANCH = 7'b1100011,                // Conditional branches
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        LOAD   = 7'b0000011,                // Recognized, not executed
        STORE  = 7'b0100011                 // Recognized, not executed
    } opcode_e;

    // ALU funct3
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // Branch funct3
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    //////////////////////////////////////////////////
    // Enums and bundles
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        KIND_ALU,                           // OP and OP_IMM
        KIND_LUI,
        KIND_AUIPC,
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR,
        KIND_ILLEGAL                        // Anything unsupported
    } opKind_e;

    typedef enum logic [1:0] {
        IDLE,                               // Waiting for req
        EXEC,                               // Units evaluate
        DONE                                // Holding rsp, ack
    } hsState_e;

    typedef struct packed {
        word_t instr;
        word_t pc;
        word_t rs1Val;
        word_t rs2Val;
    } execReq_t;                            // 128 bits

    typedef struct packed {
        opKind_e  kind;
        funct3_t  funct3;
        logic     altFunc;                  // Instruction bit 30
        logic     useImm;                   // Operand B is imm
        regAddr_t rd;
        word_t    rs1Val;
        word_t    rs2Val;
        word_t    imm;                      // Sign extended
        word_t    pc;
    } decodedOp_t;

    typedef struct packed {
        logic  taken;
        word_t target;
        word_t link;                        // pc + 4
    } branchRes_t;

    typedef struct packed {
        logic     rdWrite;
        regAddr_t rd;
        word_t    rdValue;
        word_t    nextPc;
        logic     illegal;
    } execRsp_t;

endpackage

/* source/instrDecode.sv */
`timescale 1ns/1ps
// Four-phase req/ack front end, one request in flight at a time
// reqData must stay stable while req is high and ack is low
// Unknown opcodes, loads and stores decode as KIND_ILLEGAL

module instrDecode import rvExecPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic       req,
    input  execReq_t   reqData,
    output logic       ack,
    output logic       execValid,
    output decodedOp_t dec
);

    hsState_e   hsState;
    decodedOp_t decNext;
    logic       capture;
    word_t      instr;
    logic [6:0] opField;
    word_t      immI;
    word_t      immS;
    word_t      immB;
    word_t      immU;
    word_t      immJ;

    assign instr     = reqData.instr;
    assign opField   = instr[6:0];
    assign capture   = (hsState == IDLE) && req && !ack;   // Accept edge
    assign execValid = (hsState == EXEC);                  // One cycle only

    //////////////////////////////////////////////////
    // Immediate formats
    //////////////////////////////////////////////////
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Field decode and classification
    always_comb begin
        decNext.funct3  = instr[14:12];
        decNext.altFunc = instr[30];                       // sub / sra select
        decNext.useImm  = (opField != OP);                 // Only OP reads rs2
        decNext.rd      = instr[11:7];
        decNext.rs1Val  = reqData.rs1Val;
        decNext.rs2Val  = reqData.rs2Val;
        decNext.pc      = reqData.pc;
        decNext.kind    = KIND_ILLEGAL;
        decNext.imm     = immI;                            // I-type default
        case (opField)
            OP, OP_IMM: begin
                decNext.kind = KIND_ALU;
            end
            BRANCH: begin
                decNext.kind = KIND_BRANCH;
                decNext.imm  = immB;
            end
            JAL: begin
                decNext.kind = KIND_JAL;
                decNext.imm  = immJ;
            end
            JALR: begin
                decNext.kind = KIND_JALR;                  // I-type imm
            end
            LUI: begin
                decNext.kind = KIND_LUI;
                decNext.imm  = immU;
            end
            AUIPC: begin
                decNext.kind = KIND_AUIPC;
                decNext.imm  = immU;
            end
            STORE: begin
                decNext.imm = immS;                        // Still illegal
            end
            default: begin
                decNext.kind = KIND_ILLEGAL;               // LOAD lands here too
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hsState <= IDLE;
            ack     <= 1'b0;
        end else begin
            case (hsState)
                IDLE: begin
                    if (capture) begin
                        hsState <= EXEC;
                    end
                end
                EXEC: begin
                    hsState <= DONE;                       // rsp registered here
                end
                DONE: begin
                    if (!ack) begin
                        ack <= 1'b1;                       // Edge N+2
                    end else if (!req) begin
                        ack     <= 1'b0;                   // Requester released
                        hsState <= IDLE;
                    end
                end
                default: begin
                    hsState <= IDLE;
                end
            endcase
        end
    end

    // Decoded op held for the whole transaction
    always_ff @(posedge clk) begin
        if (capture) begin
            dec <= decNext;
        end
    end

    // Requester may not withdraw before ack
    reqHeldUntilAck: assert property (@(posedge clk) disable iff (!arstN)
        (hsState != IDLE && !ack) |-> req);

endmodule

/* source/aluUnit.sv */
`timescale 1ns/1ps
// Combinational integer datapath, valid while dec is stable in EXEC
// Result is zero for kinds that do not use the ALU

module aluUnit import rvExecPkg::*; (
    input  decodedOp_t dec,
    output word_t      aluResult
);

    word_t              opA;
    word_t              opB;
    logic [SHAMT_W-1:0] shamt;
    word_t              aluOp;

    assign opA   = dec.rs1Val;
    assign opB   = dec.useImm ? dec.imm : dec.rs2Val;      // OP_IMM takes imm
    assign shamt = opB[SHAMT_W-1:0];                       // Low 5 bits only

    //////////////////////////////////////////////////
    // Funct3 operations
    //////////////////////////////////////////////////
    always_comb begin
        case (dec.funct3)
            F3_ADD_SUB: begin
                // Bit 30 is immediate data in addi
                aluOp = (dec.altFunc && !dec.useImm) ? opA - opB : opA + opB;
            end
            F3_SLL:  aluOp = opA << shamt;
            F3_SLT:  aluOp = word_t'($signed(opA) < $signed(opB));
            F3_SLTU: aluOp = word_t'(opA < opB);
            F3_XOR:  aluOp = opA ^ opB;
            F3_SRL_SRA: begin
                if (dec.altFunc) begin
                    aluOp = word_t'($signed(opA) >>> shamt);   // Arithmetic
                end else begin
                    aluOp = opA >> shamt;
                end
            end
            F3_OR:   aluOp = opA | opB;
            F3_AND:  aluOp = opA & opB;
            default: aluOp = '0;
        endcase
    end

    // Kind select
    always_comb begin
        case (dec.kind)
            KIND_ALU: begin
                aluResult = aluOp;
            end
            KIND_LUI: begin
                aluResult = dec.imm;                       // Upper imm as is
            end
            KIND_AUIPC: begin
                aluResult = dec.pc + dec.imm;
            end
            default: begin
                aluResult = '0;                            // Branch, jump, illegal
            end
        endcase
    end

endmodule

/* source/branchUnit.sv */
`timescale 1ns/1ps
// Branch condition, jump target and link address, purely combinational
// Target bit 0 is cleared for JALR only; misaligned targets are not flagged

module branchUnit import rvExecPkg::*; (
    input  decodedOp_t dec,
    output branchRes_t br
);

    word_t a;
    word_t b;
    logic  cond;
    word_t pcRel;
    word_t regRel;

    assign a      = dec.rs1Val;
    assign b      = dec.rs2Val;
    assign pcRel  = dec.pc + dec.imm;                      // Branch and JAL
    assign regRel = dec.rs1Val + dec.imm;                  // JALR base

    //////////////////////////////////////////////////
    // Branch conditions
    //////////////////////////////////////////////////
    always_comb begin
        case (dec.funct3)
            F3_BEQ:  cond = (a == b);
            F3_BNE:  cond = (a != b);
            F3_BLT:  cond = ($signed(a) < $signed(b));     // Signed
            F3_BGE:  cond = ($signed(a) >= $signed(b));
            F3_BLTU: cond = (a < b);                       // Unsigned
            F3_BGEU: cond = (a >= b);
            default: cond = 1'b0;                          // Reserved codes
        endcase
    end

    always_comb begin
        br.link = dec.pc + INSN_BYTES;
        case (dec.kind)
            KIND_BRANCH: begin
                br.taken  = cond;
                br.target = pcRel;
            end
            KIND_JAL: begin
                br.taken  = 1'b1;
                br.target = pcRel;
            end
            KIND_JALR: begin
                br.taken  = 1'b1;
                br.target = {regRel[XLEN-1:1], 1'b0};      // Clear bit 0
            end
            default: begin
                br.taken  = 1'b0;
                br.target = pcRel;                         // Unused when not taken
            end
        endcase
    end

endmodule

/* source/resultMerge.sv */
`timescale 1ns/1ps
// Combines ALU and branch outputs into the registered response
// rsp loads only on execValid and holds through DONE

module resultMerge import rvExecPkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic       execValid,
    input  decodedOp_t dec,
    input  word_t      aluResult,
    input  branchRes_t br,
    output execRsp_t   rsp
);

    execRsp_t rspNext;
    logic     writesRd;
    logic     isJump;

    assign isJump = (dec.kind == KIND_JAL) || (dec.kind == KIND_JALR);

    // Kinds with a destination register
    always_comb begin
        case (dec.kind)
            KIND_ALU, KIND_LUI, KIND_AUIPC, KIND_JAL, KIND_JALR: begin
                writesRd = 1'b1;
            end
            default: begin
                writesRd = 1'b0;                           // Branch, illegal
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Response assembly
    //////////////////////////////////////////////////
    always_comb begin
        rspNext.rdWrite = writesRd && (dec.rd != '0);      // x0 never written
        rspNext.rd      = dec.rd;
        rspNext.rdValue = isJump ? br.link : aluResult;    // Link for jumps
        rspNext.nextPc  = br.taken ? br.target : br.link;  // Link is pc + 4
        rspNext.illegal = (dec.kind == KIND_ILLEGAL);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rsp <= '0;
        end else if (execValid) begin
            rsp <= rspNext;                                // Edge ending EXEC
        end
    end

    // Decoder strobes execValid for one cycle per transaction
    singleExecPulse: assert property (@(posedge clk) disable iff (!arstN)
        execValid |=> !execValid);

endmodule

/* source/rvExecTop.sv */
`timescale 1ns/1ps
// RV32I execute core behind a four-phase req/ack handshake
// Fixed latency of 2 cycles from capture to ack; rsp valid while ack is high

module rvExecTop import rvExecPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     req,
    input  execReq_t reqData,
    output logic     ack,
    output execRsp_t rsp
);

    decodedOp_t dec;
    logic       execValid;
    word_t      aluResult;
    branchRes_t br;

    instrDecode i_instrDecode (
        .clk       (clk),
        .arstN     (arstN),
        .req       (req),
        .reqData   (reqData),
        .ack       (ack),
        .execValid (execValid),
        .dec       (dec)
    );

    // ALU and branch unit work side by side
    aluUnit i_aluUnit (
        .dec       (dec),
        .aluResult (aluResult)
    );

    branchUnit i_branchUnit (
        .dec (dec),
        .br  (br)
    );

    resultMerge i_resultMerge (
        .clk       (clk),
        .arstN     (arstN),
        .execValid (execValid),
        .dec       (dec),
        .aluResult (aluResult),
        .br        (br),
        .rsp       (rsp)
    );

endmodule

/* bench/rvExecTb.sv */
`timescale 1ns/1ps
// Directed tests for the RV32I execute core over four-phase req/ack
// Expected responses come from a spec-level model of RV32I in this file
// Inputs change on rising edges, outputs are sampled on falling edges

module rvExecTb import rvExecPkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TRANS    = 41;               // Transactions in all tests
    localparam int TRANS_CYCLES = 20;               // Budget per transaction

    logic     clk = 1'b0;
    logic     arstN;
    logic     req;
    execReq_t reqData;
    logic     ack;
    execRsp_t rsp;
    integer   seed = 32'h1901_d0e1;
    int       errCount = 0;
    int       checkCount = 0;

    rvExecTop i_dut (
        .clk     (clk),
        .arstN   (arstN),
        .req     (req),
        .reqData (reqData),
        .ack     (ack),
        .rsp     (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // Encoders and reference model
    //////////////////////////////////////////////////
    function automatic word_t rType(input logic [6:0] f7, input logic [2:0] f3,
                                    input logic [4:0] rd);
        rType = {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};    // rs2 = x2, rs1 = x1
    endfunction

    function automatic word_t iType(input logic [11:0] imm, input logic [2:0] f3,
                                    input logic [4:0] rd, input logic [6:0] opc);
        iType = {imm, 5'd1, f3, rd, opc};
    endfunction

    function automatic word_t bType(input logic [12:0] off, input logic [2:0] f3);
        bType = {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t jType(input logic [20:0] off, input logic [4:0] rd);
        jType = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t uType(input logic [19:0] imm, input logic [4:0] rd,
                                    input logic [6:0] opc);
        uType = {imm, rd, opc};
    endfunction

    function automatic word_t randWord();
        randWord = $random(seed);
    endfunction

    function automatic execRsp_t refModel(input execReq_t r);
        execRsp_t    e;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [4:0]  sh;
        logic        writes;
        logic        taken;
        word_t       a;
        word_t       b;
        word_t       immI;
        word_t       immB;
        word_t       immJ;
        word_t       immU;
        opc    = r.instr[6:0];
        f3     = r.instr[14:12];
        immI   = {{20{r.instr[31]}}, r.instr[31:20]};
        immB   = {{20{r.instr[31]}}, r.instr[7], r.instr[30:25], r.instr[11:8], 1'b0};
        immJ   = {{12{r.instr[31]}}, r.instr[19:12], r.instr[20], r.instr[30:21], 1'b0};
        immU   = {r.instr[31:12], 12'h000};
        a      = r.rs1Val;
        b      = (opc == 7'b0110011) ? r.rs2Val : immI;
        sh     = b[4:0];
        e      = '0;
        e.rd   = r.instr[11:7];
        e.nextPc = r.pc + 32'd4;
        writes = 1'b1;
        taken  = 1'b0;
        case (opc)
            7'b0110011, 7'b0010011: begin                // OP, OP-IMM
                case (f3)
                    3'b000: e.rdValue = (opc == 7'b0110011 && r.instr[30]) ? a - b : a + b;
                    3'b001: e.rdValue = a << sh;
                    3'b010: e.rdValue = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b011: e.rdValue = (a < b) ? 32'd1 : 32'd0;
                    3'b100: e.rdValue = a ^ b;
                    3'b101: begin
                        if (r.instr[30]) begin
                            e.rdValue = $signed(a) >>> sh;   // Sign fill
                        end else begin
                            e.rdValue = a >> sh;
                        end
                    end
                    3'b110: e.rdValue = a | b;
                    default: e.rdValue = a & b;
                endcase
            end
            7'b1100011: begin                            // Branch
                writes = 1'b0;
                case (f3)
                    3'b000: taken = (a == r.rs2Val);
                    3'b001: taken = (a != r.rs2Val);
                    3'b100: taken = ($signed(a) < $signed(r.rs2Val));
                    3'b101: taken = ($signed(a) >= $signed(r.rs2Val));
                    3'b110: taken = (a < r.rs2Val);
                    3'b111: taken = (a >= r.rs2Val);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    e.nextPc = r.pc + immB;
                end
            end
            7'b1101111: begin                            // JAL
                e.rdValue = r.pc + 32'd4;
                e.nextPc  = r.pc + immJ;
            end
            7'b1100111: begin                            // JALR
                e.rdValue = r.pc + 32'd4;
                e.nextPc  = (a + immI) & ~32'd1;
            end
            7'b0110111: e.rdValue = immU;                // LUI
            7'b0010111: e.rdValue = r.pc + immU;         // AUIPC
            default: begin
                writes    = 1'b0;
                e.illegal = 1'b1;
            end
        endcase
        e.rdWrite = writes && (e.rd != 5'd0);
        refModel  = e;
    endfunction

    //////////////////////////////////////////////////
    // Check and transaction tasks
    //////////////////////////////////////////////////
    task automatic checkEq(input string testName, input word_t expVal, input word_t actVal);
        checkCount = checkCount + 1;
        if (expVal !== actVal) begin
            errCount = errCount + 1;
            $display("ERR %s expected %h actual %h", testName, expVal, actVal);
        end
    endtask

    task automatic runOp(input string name, input word_t instr, input word_t pc,
                         input word_t rs1, input word_t rs2);
        execReq_t r;
        execRsp_t e;
        r.instr  = instr;
        r.pc     = pc;
        r.rs1Val = rs1;
        r.rs2Val = rs2;
        e = refModel(r);
        @(posedge clk);
        reqData <= r;
        req     <= 1'b1;
        @(negedge clk);
        while (!ack) @(negedge clk);                     // Watchdog bounds this
        checkEq({name, " rdWrite"}, 32'(e.rdWrite), 32'(rsp.rdWrite));
        if (e.rdWrite) begin
            checkEq({name, " rd"}, 32'(e.rd), 32'(rsp.rd));
            checkEq({name, " rdValue"}, e.rdValue, rsp.rdValue);
        end
        checkEq({name, " nextPc"}, e.nextPc, rsp.nextPc);
        checkEq({name, " illegal"}, 32'(e.illegal), 32'(rsp.illegal));
        @(posedge clk);
        req <= 1'b0;
        while (ack) @(negedge clk);                      // Four-phase return
    endtask

    // Fixed 2-cycle latency and ack hold under a slow requester
    task automatic checkLatency();
        execReq_t r;
        r.instr  = rType(7'h00, 3'b000, 5'd3);
        r.pc     = 32'h0000_0100;
        r.rs1Val = 32'd40;
        r.rs2Val = 32'd2;
        @(posedge clk);
        reqData <= r;
        req     <= 1'b1;
        @(posedge clk);                                  // Capture edge N
        @(negedge clk);
        checkEq("latency ack after N", 32'd0, 32'(ack));
        @(negedge clk);
        checkEq("latency ack after N+1", 32'd0, 32'(ack));
        @(negedge clk);
        checkEq("latency ack after N+2", 32'd1, 32'(ack));
        checkEq("latency rdValue", 32'd42, rsp.rdValue);
        repeat (3) begin
            @(negedge clk);
            checkEq("latency ack held", 32'd1, 32'(ack));
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        checkEq("latency ack before req low seen", 32'd1, 32'(ack));
        @(negedge clk);
        checkEq("latency ack released", 32'd0, 32'(ack));
    endtask

    task automatic aluRegTests();
        runOp("add", rType(7'h00, 3'b000, 5'd5), 32'h0000_1000, randWord(), randWord());
        runOp("sub", rType(7'h20, 3'b000, 5'd6), 32'h0000_1004, randWord(), randWord());
        runOp("sll", rType(7'h00, 3'b001, 5'd7), 32'h0000_1008, randWord(), randWord());
        runOp("slt", rType(7'h00, 3'b010, 5'd8), 32'h0000_100c, randWord(), randWord());
        runOp("sltu", rType(7'h00, 3'b011, 5'd9), 32'h0000_1010, randWord(), randWord());
        runOp("xor", rType(7'h00, 3'b100, 5'd10), 32'h0000_1014, randWord(), randWord());
        runOp("srl", rType(7'h00, 3'b101, 5'd11), 32'h0000_1018, randWord(), randWord());
        runOp("sra", rType(7'h20, 3'b101, 5'd12), 32'h0000_101c, 32'h8000_0000 | randWord(),
              randWord());
        runOp("or", rType(7'h00, 3'b110, 5'd13), 32'h0000_1020, randWord(), randWord());
        runOp("and", rType(7'h00, 3'b111, 5'd14), 32'h0000_1024, randWord(), randWord());
    endtask

    task automatic aluImmTests();
        runOp("addi", iType(12'hffb, 3'b000, 5'd5, 7'h13), 32'h2000, randWord(), 32'h0);
        runOp("slti", iType(12'hfff, 3'b010, 5'd6, 7'h13), 32'h2004, 32'hffff_fff0, 32'h0);
        runOp("sltiu", iType(12'hf00, 3'b011, 5'd7, 7'h13), 32'h2008, randWord(), 32'h0);
        runOp("xori", iType(12'hfff, 3'b100, 5'd8, 7'h13), 32'h200c, randWord(), 32'h0);
        runOp("ori", iType(12'h800, 3'b110, 5'd9, 7'h13), 32'h2010, randWord(), 32'h0);
        runOp("andi", iType(12'hff0, 3'b111, 5'd10, 7'h13), 32'h2014, randWord(), 32'h0);
        runOp("slli", iType(12'h007, 3'b001, 5'd11, 7'h13), 32'h2018, randWord(), 32'h0);
        runOp("srli", iType(12'h00d, 3'b101, 5'd12, 7'h13), 32'h201c, 32'h8765_4321, 32'h0);
        runOp("srai", iType(12'h409, 3'b101, 5'd13, 7'h13), 32'h2020, 32'h8765_4321, 32'h0);
        runOp("addi x0", iType(12'hff0, 3'b000, 5'd0, 7'h13), 32'h2024, randWord(), 32'h0);
    endtask

    // Taken and not taken per condition, signed and unsigned extremes
    task automatic branchTests();
        runOp("beq t", bType(13'h0010, 3'b000), 32'h3000, 32'd5, 32'd5);
        runOp("beq n", bType(13'h0010, 3'b000), 32'h3004, 32'd5, 32'd6);
        runOp("bne t", bType(13'h1ff0, 3'b001), 32'h3008, 32'd5, 32'd6);
        runOp("bne n", bType(13'h1ff0, 3'b001), 32'h300c, 32'd7, 32'd7);
        runOp("blt t", bType(13'h0020, 3'b100), 32'h3010, 32'h8000_0000, 32'h7fff_ffff);
        runOp("blt n", bType(13'h0020, 3'b100), 32'h3014, 32'h7fff_ffff, 32'h8000_0000);
        runOp("bge t", bType(13'h1fe0, 3'b101), 32'h3018, 32'h7fff_ffff, 32'h8000_0000);
        runOp("bge n", bType(13'h1fe0, 3'b101), 32'h301c, 32'hffff_ffff, 32'h0000_0000);
        runOp("bltu t", bType(13'h0ffe, 3'b110), 32'h3020, 32'h0000_0000, 32'hffff_ffff);
        runOp("bltu n", bType(13'h0ffe, 3'b110), 32'h3024, 32'h8000_0000, 32'h7fff_ffff);
        runOp("bgeu t", bType(13'h1000, 3'b111), 32'h3028, 32'hffff_ffff, 32'h0000_0000);
        runOp("bgeu n", bType(13'h1000, 3'b111), 32'h302c, 32'h7fff_ffff, 32'h8000_0000);
    endtask

    task automatic jumpTests();
        runOp("jal fwd", jType(21'h000800, 5'd1), 32'h4000, 32'h0, 32'h0);
        runOp("jal back", jType(21'h1fff00, 5'd2), 32'h4004, 32'h0, 32'h0);
        runOp("jalr", iType(12'h004, 3'b000, 5'd3, 7'h67), 32'h4008, 32'h0000_2001, 32'h0);
        runOp("lui", uType(20'habcde, 5'd4, 7'h37), 32'h400c, 32'h0, 32'h0);
        runOp("auipc", uType(20'hfffff, 5'd5, 7'h17), 32'h4010, 32'h0, 32'h0);
    endtask

    task automatic illegalTests();
        runOp("load", iType(12'h010, 3'b010, 5'd4, 7'h03), 32'h5000, randWord(), 32'h0);
        runOp("store", iType(12'h008, 3'b010, 5'd4, 7'h23), 32'h5004, randWord(), randWord());
        runOp("undefined", 32'h0000_007f, 32'h5008, 32'h0, 32'h0);
    endtask

    //////////////////////////////////////////////////
    // Sequence, watchdog
    //////////////////////////////////////////////////
    initial begin
        arstN   <= 1'b0;
        req     <= 1'b0;
        reqData <= '0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        checkEq("reset ack", 32'd0, 32'(ack));
        checkEq("reset rsp nextPc", 32'd0, rsp.nextPc);
        @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkEq("post reset ack", 32'd0, 32'(ack));
        checkLatency();
        aluRegTests();
        aluImmTests();
        branchTests();
        jumpTests();
        illegalTests();
        $display("Summary: %0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + NUM_TRANS * TRANS_CYCLES));
        $display("Timeout: the DUT stopped answering before all tests ran");
        $display("Some tests failed");
        $finish;
    end

endmodule

/* list.f */
source/rvExecPkg.sv
source/instrDecode.sv
source/aluUnit.sv
source/branchUnit.sv
source/resultMerge.sv
source/rvExecTop.sv
bench/rvExecTb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module rvExecTb \
    --Mdir obj_dir -o rvExecSim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/rvExecSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "All tests passed" sim.log; then
    exit 0
fi
exit 1
